//--- rtl/cpu_pkg.sv
/*
 * cpu package
 * widths, opcodes, ALU operation enum and the pipeline stage-register
 * structs shared by the five-stage RV32I subset core
 */
package cpu_pkg;

  typedef logic [31:0] word_t;      // data or instruction word
  typedef logic [4:0]  reg_addr_t;  // register index
  typedef logic [5:0]  imem_addr_t; // word index into instruction memory

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      alu_src;   // second operand is the immediate
    logic      is_halt;
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_halt;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      is_halt;
    reg_addr_t rd;
    word_t     wb_data;
  } mem_wb_t;

endpackage

//--- rtl/fetch_stage.sv
/*
 * fetch stage
 * instruction memory loaded during reset, the PC and the IF/ID register
 */
module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::word_t      prog_data,
  input  logic                stall,
  input  logic                halt_seen,
  output cpu_pkg::if_id_t     if_id
);

  cpu_pkg::word_t imem [cpu_pkg::IMEM_DEPTH];
  cpu_pkg::word_t pc;
  cpu_pkg::imem_addr_t pc_idx;

  assign pc_idx = pc[7:2]; // byte PC to word index

  // program load only while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && prog_we) imem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall && !halt_seen) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id.valid <= 1'b0;
    end else if (halt_seen) begin
      if_id.valid <= 1'b0;  // nothing past the ecall
      if_id.instr <= '0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem[pc_idx];
    end
  end

endmodule

//--- rtl/decode_stage.sv
/*
 * decode stage
 * control decode, immediates, register file with write pass-through,
 * load-use detection and the ID/EX register
 */
module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::if_id_t  if_id,
  input  cpu_pkg::mem_wb_t mem_wb,
  output cpu_pkg::id_ex_t  id_ex,
  output logic             stall,
  output logic             halt_seen
);

  cpu_pkg::word_t     regs [32];
  cpu_pkg::word_t     instr, imm_i, imm_s, imm, rs1_val, rs2_val;
  cpu_pkg::reg_addr_t rs1_f, rs2_f, rd_f;
  cpu_pkg::alu_op_e   alu_op, funct_op;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic valid_dec, issue, halt_flag;
  logic reg_write, mem_read, mem_write, alu_src, is_ecall, use_rs1, use_rs2;

  assign instr  = if_id.instr;
  assign opcode = instr[6:0];
  assign rd_f   = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1_f  = instr[19:15];
  assign rs2_f  = instr[24:20];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  assign valid_dec = if_id.valid && !halt_flag;

  always_comb begin
    case (funct3)
      3'b001:  funct_op = cpu_pkg::ALU_SLL;
      3'b010:  funct_op = cpu_pkg::ALU_SLT;
      3'b100:  funct_op = cpu_pkg::ALU_XOR;
      3'b101:  funct_op = cpu_pkg::ALU_SRL;
      3'b110:  funct_op = cpu_pkg::ALU_OR;
      3'b111:  funct_op = cpu_pkg::ALU_AND;
      default: funct_op = cpu_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_src   = 1'b0;
    is_ecall  = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    alu_op    = cpu_pkg::ALU_ADD;
    imm       = imm_i;
    case (opcode)
      cpu_pkg::OP_REG: begin
        reg_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        alu_op    = (funct3 == 3'b000 && instr[30]) ? cpu_pkg::ALU_SUB : funct_op;
      end
      cpu_pkg::OP_IMM: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        use_rs1   = 1'b1;
        alu_op    = funct_op;
      end
      cpu_pkg::OP_LOAD: begin
        {reg_write, mem_read, alu_src, use_rs1} = 4'b1111;
      end
      cpu_pkg::OP_STORE: begin
        {mem_write, alu_src, use_rs1, use_rs2} = 4'b1111;
        imm = imm_s;
      end
      cpu_pkg::OP_SYSTEM: is_ecall = 1'b1;
      default: ;  // unsupported, decodes as a bubble
    endcase
  end

  // register reads with same-cycle writeback pass-through
  always_comb begin
    rs1_val = regs[rs1_f];
    rs2_val = regs[rs2_f];
    if (mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == rs1_f) rs1_val = mem_wb.wb_data;
    if (mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == rs2_f) rs2_val = mem_wb.wb_data;
    if (rs1_f == '0) rs1_val = '0;
    if (rs2_f == '0) rs2_val = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (mem_wb.reg_write && mem_wb.rd != '0) begin
      regs[mem_wb.rd] <= mem_wb.wb_data;
    end
  end

  // load in execute feeding a source of this instruction
  assign stall = valid_dec && id_ex.mem_read && id_ex.rd != '0 &&
                 ((use_rs1 && id_ex.rd == rs1_f) || (use_rs2 && id_ex.rd == rs2_f));
  assign issue = valid_dec && !stall;

  always_ff @(posedge clk) begin
    if (reset) halt_flag <= 1'b0;
    else if (valid_dec && is_ecall) halt_flag <= 1'b1;
  end

  assign halt_seen = halt_flag || (valid_dec && is_ecall);

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.reg_write <= 1'b0;
      id_ex.mem_read  <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.alu_src   <= 1'b0;
      id_ex.is_halt   <= 1'b0;
    end else begin
      id_ex.reg_write <= issue && reg_write;  // bubble on stall
      id_ex.mem_read  <= issue && mem_read;
      id_ex.mem_write <= issue && mem_write;
      id_ex.alu_src   <= issue && alu_src;
      id_ex.is_halt   <= issue && is_ecall;
      id_ex.alu_op    <= alu_op;
      id_ex.rs1       <= use_rs1 ? rs1_f : '0;
      id_ex.rs2       <= use_rs2 ? rs2_f : '0;
      id_ex.rd        <= rd_f;
      id_ex.rs1_val   <= rs1_val;
      id_ex.rs2_val   <= rs2_val;
      id_ex.imm       <= imm;
    end
  end

endmodule

//--- rtl/execute_stage.sv
/*
 * execute stage
 * operand forwarding from EX/MEM and MEM/WB, the ALU and the EX/MEM register
 */
module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::id_ex_t  id_ex,
  input  cpu_pkg::mem_wb_t mem_wb,
  output cpu_pkg::ex_mem_t ex_mem
);

  cpu_pkg::word_t op_a, op_b, fwd_b, alu_result;

  // newest producer wins, x0 never forwards
  function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_addr_t src,
                                             input cpu_pkg::word_t     reg_val,
                                             input cpu_pkg::ex_mem_t   em,
                                             input cpu_pkg::mem_wb_t   mw);
    cpu_pkg::word_t val;
    val = reg_val;
    if (src != '0) begin
      if (em.reg_write && em.rd == src) val = em.alu_result;
      else if (mw.reg_write && mw.rd == src) val = mw.wb_data;
    end
    return val;
  endfunction

  assign op_a  = forward(id_ex.rs1, id_ex.rs1_val, ex_mem, mem_wb);
  assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val, ex_mem, mem_wb);
  assign op_b  = id_ex.alu_src ? id_ex.imm : fwd_b;

  always_comb begin
    case (id_ex.alu_op)
      cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
      cpu_pkg::ALU_AND: alu_result = op_a & op_b;
      cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
      cpu_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      cpu_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      cpu_pkg::ALU_SLL: alu_result = op_a << op_b[4:0];
      cpu_pkg::ALU_SRL: alu_result = op_a >> op_b[4:0];
      default:          alu_result = op_a + op_b;  // add, also load/store address
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.is_halt   <= 1'b0;
    end else begin
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.is_halt    <= id_ex.is_halt;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= fwd_b;  // forwarded rs2 for stores
    end
  end

endmodule

//--- rtl/memory_stage.sv
/*
 * memory stage
 * word data memory, load/ALU result select and the MEM/WB register
 */
module memory_stage (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::ex_mem_t ex_mem,
  output cpu_pkg::mem_wb_t mem_wb
);

  cpu_pkg::word_t dmem [cpu_pkg::DMEM_DEPTH];
  cpu_pkg::word_t load_data, wb_data;
  logic [$clog2(cpu_pkg::DMEM_DEPTH)-1:0] dmem_idx;

  assign dmem_idx  = ex_mem.alu_result[7:2];
  assign load_data = dmem[dmem_idx];  // combinational read
  assign wb_data   = ex_mem.mem_read ? load_data : ex_mem.alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::DMEM_DEPTH; i++) dmem[i] <= '0;
    end else if (ex_mem.mem_write) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write <= 1'b0;
      mem_wb.is_halt   <= 1'b0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.is_halt   <= ex_mem.is_halt;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.wb_data   <= wb_data;
    end
  end

endmodule

//--- rtl/cpu_top.sv
/*
 * cpu top
 * five-stage pipeline for an RV32I integer subset with writeback report
 * and a sticky halted flag raised by ecall
 */
module cpu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::word_t      prog_data,
  output logic                wb_valid,
  output cpu_pkg::reg_addr_t  wb_rd,
  output cpu_pkg::word_t      wb_data,
  output logic                halted
);

  cpu_pkg::if_id_t  if_id;
  cpu_pkg::id_ex_t  id_ex;
  cpu_pkg::ex_mem_t ex_mem;
  cpu_pkg::mem_wb_t mem_wb;
  logic stall, halt_seen;

  fetch_stage u_fetch_stage (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .stall     (stall),
    .halt_seen (halt_seen),
    .if_id     (if_id)
  );

  decode_stage u_decode_stage (
    .clk       (clk),
    .reset     (reset),
    .if_id     (if_id),
    .mem_wb    (mem_wb),
    .id_ex     (id_ex),
    .stall     (stall),
    .halt_seen (halt_seen)
  );

  execute_stage u_execute_stage (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .mem_wb (mem_wb),
    .ex_mem (ex_mem)
  );

  memory_stage u_memory_stage (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .mem_wb (mem_wb)
  );

  // one strobe per retired register write, x0 writes stay silent
  assign wb_valid = mem_wb.reg_write && mem_wb.rd != '0;
  assign wb_rd    = mem_wb.rd;
  assign wb_data  = mem_wb.wb_data;

  always_ff @(posedge clk) begin
    if (reset) halted <= 1'b0;
    else if (mem_wb.is_halt) halted <= 1'b1;  // held until reset
  end

endmodule

//--- dv/cpu_chk.sv
/*
 * cpu checker
 * assertions on the writeback report and the halted flag
 */
module cpu_chk (
  input logic               clk,
  input logic               reset,
  input logic               wb_valid,
  input cpu_pkg::reg_addr_t wb_rd,
  input logic               halted
);
  timeunit 1ns;
  timeprecision 1ps;

  // x0 writes never strobe
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != '0)
    else $error("writeback strobe with rd equal to zero");

  no_wb_when_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_valid)
    else $error("writeback strobe while the core is halted");

  halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted fell without a reset");

endmodule

bind cpu_top cpu_chk u_cpu_chk (
  .clk      (clk),
  .reset    (reset),
  .wb_valid (wb_valid),
  .wb_rd    (wb_rd),
  .halted   (halted)
);

//--- dv/cpu_tb.sv
/*
 * cpu testbench
 * loads the program during reset, checks each writeback against the
 * expected list and waits for the core to halt on ecall
 */
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                clk;
  logic                reset;
  logic                prog_we;
  cpu_pkg::imem_addr_t prog_addr;
  cpu_pkg::word_t      prog_data;
  logic                wb_valid;
  cpu_pkg::reg_addr_t  wb_rd;
  cpu_pkg::word_t      wb_data;
  logic                halted;

  cpu_pkg::word_t     prog_words [$];
  string              exp_name [$];
  cpu_pkg::reg_addr_t exp_rd [$];
  cpu_pkg::word_t     exp_data [$];

  int   mismatch_count;
  int   other_errors;
  int   wb_count;     // writebacks seen so far
  int   cycle_count;
  int   cycle_limit;
  logic running;      // timeout counter enabled
  logic was_halted;

  cpu_top u_cpu_top (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare_value(input string test_name, input cpu_pkg::word_t expected,
                               input cpu_pkg::word_t actual);
    if (expected !== actual) begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch %s: expected %h actual %h", test_name, expected, actual);
    end
  endtask

  // i lines hold program words, e lines the expected writebacks
  task automatic read_stimulus(output bit ok);
    int               fd;
    int               n;
    int               rd_val;
    string            line;
    logic [8*24-1:0]  name_buf;
    cpu_pkg::word_t   value;
    ok = 1'b0;
    fd = $fopen("dv/program_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0) begin
          if (line[0] == "i") begin
            n = $sscanf(line, "i %h", value);
            if (n == 1) prog_words.push_back(value);
          end else if (line[0] == "e") begin
            n = $sscanf(line, "e %s %d %h", name_buf, rd_val, value);
            if (n == 3) begin
              exp_name.push_back($sformatf("%0s", name_buf));
              exp_rd.push_back(cpu_pkg::reg_addr_t'(rd_val));
              exp_data.push_back(value);
            end
          end
        end
      end
      $fclose(fd);
      ok = (prog_words.size() > 0);
    end
  endtask

  // one word per cycle over the load port, reset stays high
  task automatic load_program();
    foreach (prog_words[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= cpu_pkg::imem_addr_t'(i);
      prog_data <= prog_words[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  initial begin
    bit ok;
    reset          = 1'b1;
    prog_we        = 1'b0;
    prog_addr      = '0;
    prog_data      = '0;
    mismatch_count = 0;
    other_errors   = 0;
    wb_count       = 0;
    cycle_count    = 0;
    running        = 1'b0;
    read_stimulus(ok);
    if (!ok) begin
      $display("stimulus file could not be read or holds no program words");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      cycle_limit = 8 + 6 * prog_words.size() + 20;
      load_program();
      running = 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      wait (halted === 1'b1);
      repeat (6) @(posedge clk);  // room for any stray writeback
      if (wb_count != exp_data.size()) begin
        other_errors = other_errors + 1;
        $display("writeback count %0d differs from expected list length %0d",
                 wb_count, exp_data.size());
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
      if (mismatch_count == 0 && other_errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  always @(posedge clk) begin
    if (running) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("timeout: core did not halt within %0d cycles", cycle_limit);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

  // report ports settle well before the falling edge
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (halted) begin
        other_errors = other_errors + 1;
        $display("writeback to x%0d arrived after the core halted", wb_rd);
      end
      if (wb_count < exp_data.size()) begin
        compare_value({exp_name[wb_count], "_rd"}, cpu_pkg::word_t'(exp_rd[wb_count]),
                      cpu_pkg::word_t'(wb_rd));
        compare_value(exp_name[wb_count], exp_data[wb_count], wb_data);
      end else begin
        other_errors = other_errors + 1;
        $display("unexpected extra writeback to x%0d with %h", wb_rd, wb_data);
      end
      wb_count = wb_count + 1;
    end
    if (!reset && was_halted && !halted) begin
      other_errors = other_errors + 1;
      $display("halted dropped without a reset");
    end
    was_halted = halted;
  end

endmodule

//--- dv/program_stimulus.txt
# i <instruction hex>                program words in address order
# e <test name> <rd> <value hex>     expected writebacks in retirement order
i 00C00093
i FFB00113
i 002081B3
i 40208233
i 0020F2B3
i 0020E333
i 0020C3B3
i 00112433
i 003094B3
i 00315533
i FFC12593
i FFF0C613
i 7F006693
i 0FF67713
i 00D02423
i 00802783
i 00178833
i 00508013
i 001008B3
i 00000073
i 00100913
e addi_pos 1 0000000C
e addi_neg 2 FFFFFFFB
e add_fwd 3 00000007
e sub 4 00000011
e and 5 00000008
e or 6 FFFFFFFF
e xor 7 FFFFFFF7
e slt 8 00000001
e sll 9 00000600
e srl 10 01FFFFFF
e slti_neg 11 00000001
e xori_neg 12 FFFFFFF3
e ori 13 000007F0
e andi 14 000000F3
e lw_after_sw 15 000007F0
e load_use 16 000007FC
e x0_read 17 0000000C

//--- build.f
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cpu_tb
FILELIST = build.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
